// ==== files.f ====
hw/l2_chan_pkg.sv
hw/l2_chan_pack.sv
hw/l2_skid_buf.sv
hw/l2_chan_arb.sv
hw/l2_chan_front.sv
sim/l2_chan_front_tb.sv

// ==== hw/l2_chan_arb.sv ====
`timescale 1ns/1ps

module l2_chan_arb import l2_chan_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [NUM_CHAN-1:0]      chan_valid_i,
    input  l2_msg_u [NUM_CHAN-1:0]   chan_msg_i,
    output logic [NUM_CHAN-1:0]      chan_ready_o,
    input  logic                     core_ready_i,
    output logic                     core_valid_o,
    output logic [CHAN_BITS-1:0]     core_chan_o,
    output logic [COH_MSG_BITS-1:0]  core_msg_o,
    output logic [ADDR_BITS-1:0]     core_addr_o,
    output logic [DATA_BITS-1:0]     core_data_o,
    output logic [REQ_ID_BITS-1:0]   core_req_id_o,
    output logic [INVACK_BITS-1:0]   core_invack_cnt_o
);

    logic [CHAN_BITS-1:0] win;
    l2_msg_u              win_msg;

    // Scan downward so the lowest valid index is left in win
    always_comb begin
        win = CHAN_BITS'(CHAN_CPU);
        for (int i = NUM_CHAN - 1; i >= 0; i--) begin
            if (chan_valid_i[i]) begin
                win = CHAN_BITS'(i);
            end
        end
    end

    assign core_valid_o = |chan_valid_i;
    assign core_chan_o  = win;
    assign win_msg      = chan_msg_i[win];

    always_comb begin
        chan_ready_o = '0;
        if (core_valid_o && core_ready_i) begin
            chan_ready_o[win] = 1'b1;
        end
    end

    // Same bit position for addr in both views
    assign core_addr_o = win_msg.coh.addr;

    always_comb begin
        if (win == CHAN_BITS'(CHAN_CPU)) begin
            core_msg_o        = {1'b0, win_msg.cpu.cpu_msg};
            core_data_o       = win_msg.cpu.word;
            core_req_id_o     = '0;
            core_invack_cnt_o = '0;
        end else begin
            core_msg_o        = win_msg.coh.coh_msg;
            core_data_o       = win_msg.coh.line;
            core_req_id_o     = win_msg.coh.req_id;
            core_invack_cnt_o = win_msg.coh.invack_cnt;
        end
    end

    a_one_grant: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(chan_ready_o) && ((chan_ready_o & ~chan_valid_i) == '0));

endmodule

// ==== hw/l2_chan_front.sv ====
`timescale 1ns/1ps

module l2_chan_front import l2_chan_pkg::*; (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_valid_i,
    input  logic [CPU_MSG_BITS-1:0]  cpu_msg_i,
    input  logic [HSIZE_BITS-1:0]    cpu_hsize_i,
    input  logic [HPROT_BITS-1:0]    cpu_hprot_i,
    input  logic [ADDR_BITS-1:0]     cpu_addr_i,
    input  logic [DATA_BITS-1:0]     cpu_word_i,
    output logic                     cpu_ready_o,
    input  logic                     fwd_valid_i,
    input  logic [COH_MSG_BITS-1:0]  fwd_coh_msg_i,
    input  logic [REQ_ID_BITS-1:0]   fwd_req_id_i,
    input  logic [ADDR_BITS-1:0]     fwd_addr_i,
    output logic                     fwd_ready_o,
    input  logic                     rsp_valid_i,
    input  logic [COH_MSG_BITS-1:0]  rsp_coh_msg_i,
    input  logic [ADDR_BITS-1:0]     rsp_addr_i,
    input  logic [DATA_BITS-1:0]     rsp_line_i,
    input  logic [INVACK_BITS-1:0]   rsp_invack_cnt_i,
    output logic                     rsp_ready_o,
    input  logic                     core_ready_i,
    output logic                     core_valid_o,
    output logic [CHAN_BITS-1:0]     core_chan_o,
    output logic [COH_MSG_BITS-1:0]  core_msg_o,
    output logic [ADDR_BITS-1:0]     core_addr_o,
    output logic [DATA_BITS-1:0]     core_data_o,
    output logic [REQ_ID_BITS-1:0]   core_req_id_o,
    output logic [INVACK_BITS-1:0]   core_invack_cnt_o
);

    logic [NUM_CHAN-1:0]    pk_valid;
    l2_msg_u [NUM_CHAN-1:0] pk_msg;
    logic [NUM_CHAN-1:0]    buf_ready;
    logic [NUM_CHAN-1:0]    buf_valid;
    l2_msg_u [NUM_CHAN-1:0] buf_msg;
    logic [NUM_CHAN-1:0]    arb_ready;

    l2_chan_pack u_pack (
        .clk              (clk),
        .rst              (rst),
        .cpu_valid_i      (cpu_valid_i),
        .cpu_msg_i        (cpu_msg_i),
        .cpu_hsize_i      (cpu_hsize_i),
        .cpu_hprot_i      (cpu_hprot_i),
        .cpu_addr_i       (cpu_addr_i),
        .cpu_word_i       (cpu_word_i),
        .fwd_valid_i      (fwd_valid_i),
        .fwd_coh_msg_i    (fwd_coh_msg_i),
        .fwd_req_id_i     (fwd_req_id_i),
        .fwd_addr_i       (fwd_addr_i),
        .rsp_valid_i      (rsp_valid_i),
        .rsp_coh_msg_i    (rsp_coh_msg_i),
        .rsp_addr_i       (rsp_addr_i),
        .rsp_line_i       (rsp_line_i),
        .rsp_invack_cnt_i (rsp_invack_cnt_i),
        .chan_valid_o     (pk_valid),
        .chan_msg_o       (pk_msg)
    );

    for (genvar c = 0; c < NUM_CHAN; c++) begin : g_buf
        l2_skid_buf u_buf (
            .clk         (clk),
            .rst         (rst),
            .in_valid_i  (pk_valid[c]),
            .in_msg_i    (pk_msg[c]),
            .in_ready_o  (buf_ready[c]),
            .out_valid_o (buf_valid[c]),
            .out_msg_o   (buf_msg[c]),
            .out_ready_i (arb_ready[c])
        );
    end

    assign cpu_ready_o = buf_ready[CHAN_CPU];
    assign fwd_ready_o = buf_ready[CHAN_FWD];
    assign rsp_ready_o = buf_ready[CHAN_RSP];

    l2_chan_arb u_arb (
        .clk               (clk),
        .rst               (rst),
        .chan_valid_i      (buf_valid),
        .chan_msg_i        (buf_msg),
        .chan_ready_o      (arb_ready),
        .core_ready_i      (core_ready_i),
        .core_valid_o      (core_valid_o),
        .core_chan_o       (core_chan_o),
        .core_msg_o        (core_msg_o),
        .core_addr_o       (core_addr_o),
        .core_data_o       (core_data_o),
        .core_req_id_o     (core_req_id_o),
        .core_invack_cnt_o (core_invack_cnt_o)
    );

endmodule

// ==== hw/l2_chan_pack.sv ====
`timescale 1ns/1ps

module l2_chan_pack import l2_chan_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cpu_valid_i,
    input  logic [CPU_MSG_BITS-1:0]   cpu_msg_i,
    input  logic [HSIZE_BITS-1:0]     cpu_hsize_i,
    input  logic [HPROT_BITS-1:0]     cpu_hprot_i,
    input  logic [ADDR_BITS-1:0]      cpu_addr_i,
    input  logic [DATA_BITS-1:0]      cpu_word_i,
    input  logic                      fwd_valid_i,
    input  logic [COH_MSG_BITS-1:0]   fwd_coh_msg_i,
    input  logic [REQ_ID_BITS-1:0]    fwd_req_id_i,
    input  logic [ADDR_BITS-1:0]      fwd_addr_i,
    input  logic                      rsp_valid_i,
    input  logic [COH_MSG_BITS-1:0]   rsp_coh_msg_i,
    input  logic [ADDR_BITS-1:0]      rsp_addr_i,
    input  logic [DATA_BITS-1:0]      rsp_line_i,
    input  logic [INVACK_BITS-1:0]    rsp_invack_cnt_i,
    output logic [NUM_CHAN-1:0]       chan_valid_o,
    output l2_msg_u [NUM_CHAN-1:0]    chan_msg_o
);

    assign chan_valid_o[CHAN_RSP] = rsp_valid_i;
    assign chan_valid_o[CHAN_FWD] = fwd_valid_i;
    assign chan_valid_o[CHAN_CPU] = cpu_valid_i;

    always_comb begin
        chan_msg_o = '0;

        chan_msg_o[CHAN_CPU].cpu.cpu_msg = cpu_msg_i;
        chan_msg_o[CHAN_CPU].cpu.hsize   = cpu_hsize_i;
        chan_msg_o[CHAN_CPU].cpu.hprot   = cpu_hprot_i;
        chan_msg_o[CHAN_CPU].cpu.addr    = cpu_addr_i;
        chan_msg_o[CHAN_CPU].cpu.word    = cpu_word_i;

        // Forwards carry no data and no ack count
        chan_msg_o[CHAN_FWD].coh.coh_msg = fwd_coh_msg_i;
        chan_msg_o[CHAN_FWD].coh.req_id  = fwd_req_id_i;
        chan_msg_o[CHAN_FWD].coh.addr    = fwd_addr_i;

        chan_msg_o[CHAN_RSP].coh.coh_msg    = rsp_coh_msg_i;
        chan_msg_o[CHAN_RSP].coh.invack_cnt = rsp_invack_cnt_i;
        chan_msg_o[CHAN_RSP].coh.addr       = rsp_addr_i;
        chan_msg_o[CHAN_RSP].coh.line       = rsp_line_i;
    end

    // Coherence codes above the legal maximum
    a_fwd_code: assert property (@(posedge clk) disable iff (!rst)
        chan_valid_o[CHAN_FWD] |-> chan_msg_o[CHAN_FWD].coh.coh_msg <= COH_MSG_MAX);

    a_rsp_code: assert property (@(posedge clk) disable iff (!rst)
        chan_valid_o[CHAN_RSP] |-> chan_msg_o[CHAN_RSP].coh.coh_msg <= COH_MSG_MAX);

    a_cpu_hsize: assert property (@(posedge clk) disable iff (!rst)
        chan_valid_o[CHAN_CPU] |-> chan_msg_o[CHAN_CPU].cpu.hsize <= HSIZE_WORD);

endmodule

// ==== hw/l2_chan_pkg.sv ====
package l2_chan_pkg;

    localparam int ADDR_BITS = 24;
    localparam int DATA_BITS = 16;
    localparam int MSG_BITS  = 49;

    localparam int NUM_CHAN  = 3;
    localparam int CHAN_BITS = 2;
    // Lower index wins arbitration
    localparam int CHAN_RSP  = 0;
    localparam int CHAN_FWD  = 1;
    localparam int CHAN_CPU  = 2;

    localparam int CPU_MSG_BITS = 2;
    localparam int COH_MSG_BITS = 3;
    localparam int HSIZE_BITS   = 3;
    localparam int HPROT_BITS   = 2;
    localparam int REQ_ID_BITS  = 2;
    localparam int INVACK_BITS  = 4;
    localparam int CPU_PAD_BITS = MSG_BITS - ADDR_BITS - DATA_BITS - CPU_MSG_BITS
                                  - HSIZE_BITS - HPROT_BITS;

    localparam logic [CPU_MSG_BITS-1:0] CPU_MSG_READ       = 2'd0;
    localparam logic [CPU_MSG_BITS-1:0] CPU_MSG_WRITE      = 2'd1;
    localparam logic [CPU_MSG_BITS-1:0] CPU_MSG_READ_ATOM  = 2'd2;
    localparam logic [CPU_MSG_BITS-1:0] CPU_MSG_WRITE_ATOM = 2'd3;

    localparam logic [COH_MSG_BITS-1:0] COH_MSG_MAX = 3'd6;

    // Halfword, the widest access into a 16-bit word
    localparam logic [HSIZE_BITS-1:0] HSIZE_WORD = 3'd1;

    // addr lines up in both views
    typedef union packed {
        struct packed {
            logic [CPU_MSG_BITS-1:0] cpu_msg;
            logic [HSIZE_BITS-1:0]   hsize;
            logic [HPROT_BITS-1:0]   hprot;
            logic [CPU_PAD_BITS-1:0] pad;
            logic [ADDR_BITS-1:0]    addr;
            logic [DATA_BITS-1:0]    word;
        } cpu;
        struct packed {
            logic [COH_MSG_BITS-1:0] coh_msg;
            logic [REQ_ID_BITS-1:0]  req_id;
            logic [INVACK_BITS-1:0]  invack_cnt;
            logic [ADDR_BITS-1:0]    addr;
            logic [DATA_BITS-1:0]    line;
        } coh;
    } l2_msg_u;

endpackage

// ==== hw/l2_skid_buf.sv ====
`timescale 1ns/1ps

module l2_skid_buf import l2_chan_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    in_valid_i,
    input  l2_msg_u in_msg_i,
    output logic    in_ready_o,
    output logic    out_valid_o,
    output l2_msg_u out_msg_o,
    input  logic    out_ready_i
);

    logic    full_q;
    l2_msg_u entry_q;
    logic    store;

    // Accepted but not taken downstream this cycle
    assign store = in_valid_i && in_ready_o && !out_ready_i;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            full_q <= 1'b0;
        end else if (store) begin
            full_q <= 1'b1;
        end else if (full_q && out_ready_i) begin
            full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            entry_q <= in_msg_i;
        end
    end

    assign in_ready_o = !full_q;

    // Empty entry means zero-cycle bypass
    assign out_valid_o = full_q || in_valid_i;
    assign out_msg_o   = full_q ? entry_q : in_msg_i;

    a_hold_stable: assert property (@(posedge clk) disable iff (!rst)
        (full_q && !out_ready_i) |=> (full_q && $stable(entry_q)));

    // A stored word blocks the input until it leaves
    a_block_on_store: assert property (@(posedge clk) disable iff (!rst)
        store |=> !in_ready_o);

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module l2_chan_front_tb -f files.f \
    -o l2_chan_front_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/l2_chan_front_sim > sim.log 2>&1
cat sim.log

grep -q "Finished with no errors" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

// ==== sim/l2_chan_front_tb.sv ====
`timescale 1ns/1ps

module l2_chan_front_tb import l2_chan_pkg::*; ();

    localparam int N_ROWS      = 14;
    localparam int RAND_CYCLES = 400;
    localparam int DRAIN_LIMIT = 20;

    localparam logic [CHAN_BITS-1:0] C_RSP = CHAN_BITS'(CHAN_RSP);
    localparam logic [CHAN_BITS-1:0] C_FWD = CHAN_BITS'(CHAN_FWD);
    localparam logic [CHAN_BITS-1:0] C_CPU = CHAN_BITS'(CHAN_CPU);

    // e_fields is {msg, addr, data, req_id, invack_cnt} as seen on the core port
    typedef struct packed {
        logic                    rv;
        logic [COH_MSG_BITS-1:0] rmsg;
        logic [ADDR_BITS-1:0]    raddr;
        logic [DATA_BITS-1:0]    rline;
        logic [INVACK_BITS-1:0]  rinv;
        logic                    fv;
        logic [COH_MSG_BITS-1:0] fmsg;
        logic [REQ_ID_BITS-1:0]  freq;
        logic [ADDR_BITS-1:0]    faddr;
        logic                    cv;
        logic [CPU_MSG_BITS-1:0] cmsg;
        logic [HSIZE_BITS-1:0]   chsize;
        logic [HPROT_BITS-1:0]   chprot;
        logic [ADDR_BITS-1:0]    caddr;
        logic [DATA_BITS-1:0]    cword;
        logic                    core_rdy;
        logic [NUM_CHAN-1:0]     e_rdy;
        logic                    e_valid;
        logic [CHAN_BITS-1:0]    e_chan;
        logic [48:0]             e_fields;
    } row_t;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cpu_valid_i;
    logic [CPU_MSG_BITS-1:0] cpu_msg_i;
    logic [HSIZE_BITS-1:0]   cpu_hsize_i;
    logic [HPROT_BITS-1:0]   cpu_hprot_i;
    logic [ADDR_BITS-1:0]    cpu_addr_i;
    logic [DATA_BITS-1:0]    cpu_word_i;
    logic                    cpu_ready_o;
    logic                    fwd_valid_i;
    logic [COH_MSG_BITS-1:0] fwd_coh_msg_i;
    logic [REQ_ID_BITS-1:0]  fwd_req_id_i;
    logic [ADDR_BITS-1:0]    fwd_addr_i;
    logic                    fwd_ready_o;
    logic                    rsp_valid_i;
    logic [COH_MSG_BITS-1:0] rsp_coh_msg_i;
    logic [ADDR_BITS-1:0]    rsp_addr_i;
    logic [DATA_BITS-1:0]    rsp_line_i;
    logic [INVACK_BITS-1:0]  rsp_invack_cnt_i;
    logic                    rsp_ready_o;
    logic                    core_ready_i;
    logic                    core_valid_o;
    logic [CHAN_BITS-1:0]    core_chan_o;
    logic [COH_MSG_BITS-1:0] core_msg_o;
    logic [ADDR_BITS-1:0]    core_addr_o;
    logic [DATA_BITS-1:0]    core_data_o;
    logic [REQ_ID_BITS-1:0]  core_req_id_o;
    logic [INVACK_BITS-1:0]  core_invack_cnt_o;

    row_t        rows [N_ROWS];
    logic [48:0] ref_q [NUM_CHAN][$];
    int          seed;
    int          errors;
    int          n_tests;
    int          mark;
    int          waited;

    always #5 clk = ~clk;

    l2_chan_front dut0 (.*);

    task automatic load_table();
        rows[0] = '{core_rdy: 1'b1, e_rdy: 3'b111, default: '0};
        rows[1] = '{cv: 1'b1, cmsg: CPU_MSG_WRITE, chsize: 3'd1, chprot: 2'd2,
                    caddr: 24'h12_3456, cword: 16'hcafe, core_rdy: 1'b1, e_rdy: 3'b111,
                    e_valid: 1'b1, e_chan: C_CPU,
                    e_fields: {3'd1, 24'h12_3456, 16'hcafe, 2'd0, 4'd0}, default: '0};
        rows[2] = '{rv: 1'b1, rmsg: 3'd5, raddr: 24'hab_cdef, rline: 16'h5a5a, rinv: 4'd9,
                    core_rdy: 1'b1, e_rdy: 3'b111, e_valid: 1'b1, e_chan: C_RSP,
                    e_fields: {3'd5, 24'hab_cdef, 16'h5a5a, 2'd0, 4'd9}, default: '0};
        rows[3] = '{fv: 1'b1, fmsg: 3'd3, freq: 2'd2, faddr: 24'h00_0f0f,
                    core_rdy: 1'b1, e_rdy: 3'b111, e_valid: 1'b1, e_chan: C_FWD,
                    e_fields: {3'd3, 24'h00_0f0f, 16'h0, 2'd2, 4'd0}, default: '0};
        // All three at once, then the stored words leave one per cycle
        rows[4] = '{rv: 1'b1, rmsg: 3'd1, raddr: 24'h10_0001, rline: 16'h1111, rinv: 4'd2,
                    fv: 1'b1, fmsg: 3'd2, freq: 2'd1, faddr: 24'h20_0002,
                    cv: 1'b1, cmsg: CPU_MSG_READ, chprot: 2'd1, caddr: 24'h30_0003,
                    cword: 16'h3333, core_rdy: 1'b1, e_rdy: 3'b111, e_valid: 1'b1,
                    e_chan: C_RSP, e_fields: {3'd1, 24'h10_0001, 16'h1111, 2'd0, 4'd2},
                    default: '0};
        rows[5] = '{core_rdy: 1'b1, e_rdy: 3'b001, e_valid: 1'b1, e_chan: C_FWD,
                    e_fields: {3'd2, 24'h20_0002, 16'h0, 2'd1, 4'd0}, default: '0};
        rows[6] = '{core_rdy: 1'b1, e_rdy: 3'b011, e_valid: 1'b1, e_chan: C_CPU,
                    e_fields: {3'd0, 24'h30_0003, 16'h3333, 2'd0, 4'd0}, default: '0};
        rows[7] = '{core_rdy: 1'b1, e_rdy: 3'b111, default: '0};
        // Core stalled, every channel takes one word
        rows[8] = '{rv: 1'b1, rmsg: 3'd6, raddr: 24'h40_0004, rline: 16'h4444, rinv: 4'd15,
                    fv: 1'b1, fmsg: 3'd0, freq: 2'd3, faddr: 24'h50_0005,
                    cv: 1'b1, cmsg: CPU_MSG_WRITE_ATOM, chsize: 3'd1, chprot: 2'd3,
                    caddr: 24'h60_0006, cword: 16'h6666, core_rdy: 1'b0, e_rdy: 3'b111,
                    e_valid: 1'b1, e_chan: C_RSP,
                    e_fields: {3'd6, 24'h40_0004, 16'h4444, 2'd0, 4'd15}, default: '0};
        rows[9] = '{core_rdy: 1'b0, e_rdy: 3'b000, e_valid: 1'b1, e_chan: C_RSP,
                    e_fields: {3'd6, 24'h40_0004, 16'h4444, 2'd0, 4'd15}, default: '0};
        rows[10] = '{core_rdy: 1'b1, e_rdy: 3'b000, e_valid: 1'b1, e_chan: C_RSP,
                     e_fields: {3'd6, 24'h40_0004, 16'h4444, 2'd0, 4'd15}, default: '0};
        rows[11] = '{core_rdy: 1'b1, e_rdy: 3'b001, e_valid: 1'b1, e_chan: C_FWD,
                     e_fields: {3'd0, 24'h50_0005, 16'h0, 2'd3, 4'd0}, default: '0};
        rows[12] = '{core_rdy: 1'b1, e_rdy: 3'b011, e_valid: 1'b1, e_chan: C_CPU,
                     e_fields: {3'd3, 24'h60_0006, 16'h6666, 2'd0, 4'd0}, default: '0};
        rows[13] = '{core_rdy: 1'b1, e_rdy: 3'b111, default: '0};
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act == exp) else begin
            $display("FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_fields(input logic [48:0] exp);
        check_val("core_msg_o", 64'(exp[48:46]), 64'(core_msg_o));
        check_val("core_addr_o", 64'(exp[45:22]), 64'(core_addr_o));
        check_val("core_data_o", 64'(exp[21:6]), 64'(core_data_o));
        check_val("core_req_id_o", 64'(exp[5:4]), 64'(core_req_id_o));
        check_val("core_invack_cnt_o", 64'(exp[3:0]), 64'(core_invack_cnt_o));
    endtask

    task automatic apply_row(input row_t r);
        @(posedge clk);
        rsp_valid_i      <= r.rv;
        rsp_coh_msg_i    <= r.rmsg;
        rsp_addr_i       <= r.raddr;
        rsp_line_i       <= r.rline;
        rsp_invack_cnt_i <= r.rinv;
        fwd_valid_i      <= r.fv;
        fwd_coh_msg_i    <= r.fmsg;
        fwd_req_id_i     <= r.freq;
        fwd_addr_i       <= r.faddr;
        cpu_valid_i      <= r.cv;
        cpu_msg_i        <= r.cmsg;
        cpu_hsize_i      <= r.chsize;
        cpu_hprot_i      <= r.chprot;
        cpu_addr_i       <= r.caddr;
        cpu_word_i       <= r.cword;
        core_ready_i     <= r.core_rdy;
        @(negedge clk);
        check_val("rsp_ready_o", 64'(r.e_rdy[CHAN_RSP]), 64'(rsp_ready_o));
        check_val("fwd_ready_o", 64'(r.e_rdy[CHAN_FWD]), 64'(fwd_ready_o));
        check_val("cpu_ready_o", 64'(r.e_rdy[CHAN_CPU]), 64'(cpu_ready_o));
        check_val("core_valid_o", 64'(r.e_valid), 64'(core_valid_o));
        if (r.e_valid) begin
            check_val("core_chan_o", 64'(r.e_chan), 64'(core_chan_o));
            check_fields(r.e_fields);
        end
    endtask

    task automatic run_rows(input string name, input int first, input int last);
        mark = errors;
        for (int i = first; i <= last; i++) begin
            apply_row(rows[i]);
        end
        report_test(name);
    endtask

    task automatic report_test(input string name);
        n_tests++;
        if (errors == mark) begin
            $display("test %0d %s: passed", n_tests, name);
        end else begin
            $display("test %0d %s: %0d errors", n_tests, name, errors - mark);
        end
    endtask

    // Expected core fields follow the decode rule of each channel
    task automatic record_accepts();
        if (rsp_valid_i && rsp_ready_o) begin
            ref_q[CHAN_RSP].push_back({rsp_coh_msg_i, rsp_addr_i, rsp_line_i, 2'd0,
                                       rsp_invack_cnt_i});
        end
        if (fwd_valid_i && fwd_ready_o) begin
            ref_q[CHAN_FWD].push_back({fwd_coh_msg_i, fwd_addr_i, 16'h0, fwd_req_id_i, 4'd0});
        end
        if (cpu_valid_i && cpu_ready_o) begin
            ref_q[CHAN_CPU].push_back({1'b0, cpu_msg_i, cpu_addr_i, cpu_word_i, 2'd0, 4'd0});
        end
    endtask

    task automatic check_transfer();
        int ch;
        if (core_valid_o && core_ready_i) begin
            ch = int'(core_chan_o);
            assert (ch < NUM_CHAN && ref_q[ch].size() != 0) else begin
                $display("Core transfer at %0t on channel %0d with no word waiting", $time, ch);
                errors++;
            end
            if (ch < NUM_CHAN && ref_q[ch].size() != 0) begin
                check_fields(ref_q[ch].pop_front());
            end
        end
    endtask

    function automatic int pending();
        return ref_q[CHAN_RSP].size() + ref_q[CHAN_FWD].size() + ref_q[CHAN_CPU].size();
    endfunction

    task automatic drive_random();
        @(posedge clk);
        rsp_valid_i      <= 1'($random(seed));
        rsp_coh_msg_i    <= 3'($unsigned($random(seed)) % 7);
        rsp_addr_i       <= 24'($random(seed));
        rsp_line_i       <= 16'($random(seed));
        rsp_invack_cnt_i <= 4'($random(seed));
        fwd_valid_i      <= 1'($random(seed));
        fwd_coh_msg_i    <= 3'($unsigned($random(seed)) % 7);
        fwd_req_id_i     <= 2'($random(seed));
        fwd_addr_i       <= 24'($random(seed));
        cpu_valid_i      <= 1'($random(seed));
        cpu_msg_i        <= 2'($random(seed));
        cpu_hsize_i      <= 3'($random(seed) & 1);
        cpu_hprot_i      <= 2'($random(seed));
        cpu_addr_i       <= 24'($random(seed));
        cpu_word_i       <= 16'($random(seed));
        core_ready_i     <= (($random(seed) & 3) != 0);
    endtask

    initial begin
        seed = 32'h3f72_763a;
        errors = 0;
        n_tests = 0;
        rst = 1'b0;
        load_table();
        apply_idle();
        repeat (10) @(posedge clk);
        rst <= 1'b1;

        run_rows("reset state", 0, 0);
        run_rows("cpu bypass", 1, 1);
        run_rows("coherence decode", 2, 3);
        run_rows("priority", 4, 7);
        run_rows("back-pressure", 8, 13);

        mark = errors;
        for (int n = 0; n < RAND_CYCLES; n++) begin
            drive_random();
            @(negedge clk);
            record_accepts();
            check_transfer();
        end
        @(posedge clk);
        apply_idle();
        core_ready_i <= 1'b1;
        waited = 0;
        while (pending() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            check_transfer();
            waited++;
        end
        assert (pending() == 0) else begin
            $display("Drain timed out with %0d words still waiting", pending());
            errors++;
        end
        report_test("random stall");

        $display("tests %0d, errors %0d", n_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    task automatic apply_idle();
        rsp_valid_i      <= 1'b0;
        rsp_coh_msg_i    <= '0;
        rsp_addr_i       <= '0;
        rsp_line_i       <= '0;
        rsp_invack_cnt_i <= '0;
        fwd_valid_i      <= 1'b0;
        fwd_coh_msg_i    <= '0;
        fwd_req_id_i     <= '0;
        fwd_addr_i       <= '0;
        cpu_valid_i      <= 1'b0;
        cpu_msg_i        <= '0;
        cpu_hsize_i      <= '0;
        cpu_hprot_i      <= '0;
        cpu_addr_i       <= '0;
        cpu_word_i       <= '0;
        core_ready_i     <= 1'b1;
    endtask

endmodule
